/* cw_capture_top.f */
design/cw_bus_pkg.sv
design/cw_target_pkg.sv
design/usb_reg_main.sv
design/reg_adc_ctrl.sv
design/reg_trigger_io.sv
design/reg_status.sv
design/cw_capture_top.sv
verif/tb_cw_capture_top.sv

/* design/cw_bus_pkg.sv */
`default_nettype none

package cw_bus_pkg;

   localparam int BYTECNT_W = 7;   // byte counter width, fixed

   // read data word as returned by every register block
   typedef logic [7:0] rdata_t;

   // register bus from the host front end
   typedef struct packed {
      logic [7:0]           addr;      // latched on ALE
      logic [BYTECNT_W-1:0] bytecnt;   // byte index within an ALE
      logic [7:0]           wdata;
      logic                 rd;        // one-cycle read pulse
      logic                 wr;        // one-cycle write pulse
      logic                 addrvalid; // set after first ALE
   } reg_bus_t;

   // ADC configuration block
   localparam logic [7:0] ADDR_ADC_CTRL  = 8'h00;
   localparam logic [7:0] ADDR_ADC_SPI   = 8'h01;
   localparam logic [7:0] ADDR_ADC_STAT  = 8'h02;
   localparam logic [7:0] ADDR_VMAG      = 8'h03;

   // trigger and target pins
   localparam logic [7:0] ADDR_TRIG_MASK = 8'h10;
   localparam logic [7:0] ADDR_TRIG_MODE = 8'h11;
   localparam logic [7:0] ADDR_IO_CTRL   = 8'h12;

   // status
   localparam logic [7:0] ADDR_ERR       = 8'h20;

endpackage

`default_nettype wire

/* design/cw_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cw_capture_top #(
   parameter int sclk_div = 4,
   parameter int hb_bit   = 22
) (
   input  wire                        clk_usb_buf,
   input  wire                        rst_n_i,
   // host bus
   input  wire [7:0]                  usb_addr_i,
   input  wire [7:0]                  usb_data_i,
   input  wire                        usb_rdn_i,
   input  wire                        usb_wrn_i,
   input  wire                        usb_cen_i,
   input  wire                        usb_alen_i,
   output logic [7:0]                 usb_data_o,
   output logic                       usb_data_oe_o,
   // ADC
   output logic                       adc_reset_o,
   output logic                       adc_oe_o,
   output logic                       adc_dfs_o,
   output logic                       adc_sclk_o,
   output logic                       adc_sdata_o,
   output logic                       adc_sen_o,
   output logic [4:0]                 vmag_o,
   // target
   input  wire [3:0]                  target_io_i,
   input  wire                        sam_mosi_i,
   input  wire                        sam_spck_i,
   input  wire                        target_miso_i,
   output logic                       trig_o,
   output cw_target_pkg::pin_drive_t  target_nrst_o,
   output cw_target_pkg::pin_drive_t  target_mosi_o,
   output cw_target_pkg::pin_drive_t  target_sck_o,
   output cw_target_pkg::pin_drive_t  sam_miso_o,
   // status and LED
   input  wire                        fifo_error_i,
   input  wire                        dcm_unlock_i,
   output logic                       led_fail_o
);

   cw_bus_pkg::reg_bus_t reg_bus;
   cw_bus_pkg::rdata_t   rdata_adc, rdata_trig, rdata_stat, rdata_all;

   // idle blocks return 0, so a plain OR works
   assign rdata_all = rdata_adc | rdata_trig | rdata_stat;

   usb_reg_main u_usb_reg_main (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .rdata_i       (rdata_all),
      .bus_o         (reg_bus),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o)
   );

   reg_adc_ctrl #(
      .sclk_div (sclk_div)
   ) u_reg_adc_ctrl (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .bus_i       (reg_bus),
      .rdata_o     (rdata_adc),
      .adc_reset_o (adc_reset_o),
      .adc_oe_o    (adc_oe_o),
      .adc_dfs_o   (adc_dfs_o),
      .adc_sclk_o  (adc_sclk_o),
      .adc_sdata_o (adc_sdata_o),
      .adc_sen_o   (adc_sen_o),
      .vmag_o      (vmag_o)
   );

   reg_trigger_io u_reg_trigger_io (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .bus_i         (reg_bus),
      .target_io_i   (target_io_i),
      .sam_mosi_i    (sam_mosi_i),
      .sam_spck_i    (sam_spck_i),
      .target_miso_i (target_miso_i),
      .rdata_o       (rdata_trig),
      .trig_o        (trig_o),
      .target_nrst_o (target_nrst_o),
      .target_mosi_o (target_mosi_o),
      .target_sck_o  (target_sck_o),
      .sam_miso_o    (sam_miso_o)
   );

   reg_status #(
      .hb_bit (hb_bit)
   ) u_reg_status (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .bus_i        (reg_bus),
      .fifo_error_i (fifo_error_i),
      .dcm_unlock_i (dcm_unlock_i),
      .rdata_o      (rdata_stat),
      .led_fail_o   (led_fail_o)
   );

endmodule

`default_nettype wire

/* design/cw_target_pkg.sv */
`default_nettype none

package cw_target_pkg;

   // pad model: value plus output enable, oe low means high-z
   typedef struct packed {
      logic val;
      logic oe;
   } pin_drive_t;

   // IO_CTRL register bits
   localparam int BIT_AVRPROG  = 0;   // SAM drives the AVR ISP pins
   localparam int BIT_NRST_EN  = 1;   // manual nrst drive
   localparam int BIT_NRST_VAL = 2;   // level for manual nrst
   localparam int BIT_PWR_OFF  = 3;   // target unpowered, float pins

   localparam int IO_CTRL_W    = 4;

endpackage

`default_nettype wire

/* design/reg_adc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_adc_ctrl #(
   parameter int sclk_div = 4   // sclk half period in clocks
) (
   input  wire                    clk_usb_buf,
   input  wire                    rst_n_i,
   input  cw_bus_pkg::reg_bus_t   bus_i,
   output cw_bus_pkg::rdata_t     rdata_o,
   output logic                   adc_reset_o,
   output logic                   adc_oe_o,
   output logic                   adc_dfs_o,
   output logic                   adc_sclk_o,
   output logic                   adc_sdata_o,
   output logic                   adc_sen_o,
   output logic [4:0]             vmag_o
);

   localparam int DIV_W = (sclk_div > 1) ? $clog2(sclk_div) : 1;
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(sclk_div - 1);

   logic [2:0]       ctrl_q;       // {dfs, oe, reset}
   logic [4:0]       vmag_q;
   logic [15:0]      spi_word_q;   // last word written, for readback
   logic [15:0]      shift_q;
   logic             busy_q, sen_q, sclk_q;
   logic [DIV_W-1:0] div_cnt_q;
   logic [3:0]       bit_cnt_q;

   logic wr_spi, spi_hi_wr, spi_start, div_done, sclk_fall;

   assign wr_spi    = bus_i.wr && (bus_i.addr == cw_bus_pkg::ADDR_ADC_SPI) && !busy_q;
   assign spi_hi_wr = wr_spi && (bus_i.bytecnt == 'd0);
   assign spi_start = wr_spi && (bus_i.bytecnt == 'd1);  // low byte kicks off
   assign div_done  = (div_cnt_q == DIV_LAST);
   assign sclk_fall = busy_q && div_done && sclk_q;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
         vmag_q <= '0;
      end else if (bus_i.wr) begin
         if (bus_i.addr == cw_bus_pkg::ADDR_ADC_CTRL)
            ctrl_q <= bus_i.wdata[2:0];
         if (bus_i.addr == cw_bus_pkg::ADDR_VMAG)
            vmag_q <= bus_i.wdata[4:0];
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (spi_hi_wr)
         spi_word_q[15:8] <= bus_i.wdata;
      if (spi_start)
         spi_word_q[7:0] <= bus_i.wdata;
      if (spi_start)
         shift_q <= {spi_word_q[15:8], bus_i.wdata};
      else if (sclk_fall)
         shift_q <= {shift_q[14:0], 1'b0};   // next bit while sclk low
   end

   // serial clock sequencer, sen low for the whole word
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q    <= 1'b0;
         sen_q     <= 1'b1;
         sclk_q    <= 1'b0;
         div_cnt_q <= '0;
         bit_cnt_q <= '0;
      end else if (spi_start) begin
         busy_q    <= 1'b1;
         sen_q     <= 1'b0;
         sclk_q    <= 1'b0;
         div_cnt_q <= '0;
         bit_cnt_q <= '0;
      end else if (busy_q) begin
         if (div_done) begin
            div_cnt_q <= '0;
            if (!sclk_q) begin
               sclk_q <= 1'b1;                // ADC samples here
            end else begin
               sclk_q <= 1'b0;
               if (bit_cnt_q == 4'd15) begin
                  busy_q <= 1'b0;             // 16th high phase done
                  sen_q  <= 1'b1;
               end else begin
                  bit_cnt_q <= bit_cnt_q + 1'b1;
               end
            end
         end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
         end
      end
   end

   always_comb begin
      rdata_o = '0;
      if (bus_i.rd) begin
         case (bus_i.addr)
            cw_bus_pkg::ADDR_ADC_CTRL: rdata_o = {5'b0, ctrl_q};
            cw_bus_pkg::ADDR_ADC_SPI:
               rdata_o = bus_i.bytecnt[0] ? spi_word_q[7:0] : spi_word_q[15:8];
            cw_bus_pkg::ADDR_ADC_STAT: rdata_o = {7'b0, busy_q};
            cw_bus_pkg::ADDR_VMAG:     rdata_o = {3'b0, vmag_q};
            default:                   rdata_o = '0;
         endcase
      end
   end

   assign adc_reset_o = ctrl_q[0];
   assign adc_oe_o    = ctrl_q[1];
   assign adc_dfs_o   = ctrl_q[2];
   assign vmag_o      = vmag_q;
   assign adc_sclk_o  = sclk_q;
   assign adc_sen_o   = sen_q;
   assign adc_sdata_o = busy_q & shift_q[15];   // MSB first

endmodule

`default_nettype wire

/* design/reg_status.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_status #(
   parameter int hb_bit = 22   // heartbeat bit for the LED flash
) (
   input  wire                    clk_usb_buf,
   input  wire                    rst_n_i,
   input  cw_bus_pkg::reg_bus_t   bus_i,
   input  wire                    fifo_error_i,
   input  wire                    dcm_unlock_i,
   output cw_bus_pkg::rdata_t     rdata_o,
   output logic                   led_fail_o
);

   logic [hb_bit:0] hb_cnt_q;
   logic [0:0]      err_q;   // bit0 fifo error, sticky
   logic [0:0]      err_clr;

   // write-one-to-clear
   assign err_clr = (bus_i.wr && bus_i.addr == cw_bus_pkg::ADDR_ERR) ?
                    bus_i.wdata[0:0] : 1'b0;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hb_cnt_q <= '0;
         err_q    <= '0;
      end else begin
         hb_cnt_q <= hb_cnt_q + 1'b1;               // free running
         err_q    <= (err_q & ~err_clr) | fifo_error_i;  // set wins
      end
   end

   // flash while anything is pending
   assign led_fail_o = (|err_q) ? hb_cnt_q[hb_bit] : dcm_unlock_i;

   assign rdata_o = (bus_i.rd && bus_i.addr == cw_bus_pkg::ADDR_ERR) ?
                    {7'b0, err_q} : 8'h00;

endmodule

`default_nettype wire

/* design/reg_trigger_io.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_trigger_io (
   input  wire                        clk_usb_buf,
   input  wire                        rst_n_i,
   input  cw_bus_pkg::reg_bus_t       bus_i,
   input  wire [3:0]                  target_io_i,
   input  wire                        sam_mosi_i,
   input  wire                        sam_spck_i,
   input  wire                        target_miso_i,
   output cw_bus_pkg::rdata_t         rdata_o,
   output logic                       trig_o,
   output cw_target_pkg::pin_drive_t  target_nrst_o,
   output cw_target_pkg::pin_drive_t  target_mosi_o,
   output cw_target_pkg::pin_drive_t  target_sck_o,
   output cw_target_pkg::pin_drive_t  sam_miso_o
);

   logic [3:0] mask_q;
   logic [1:0] mode_q;   // bit0 AND/OR, bit1 invert
   logic [cw_target_pkg::IO_CTRL_W-1:0] io_ctrl_q;
   logic       trig_q;

   logic and_hit, or_hit, trig_raw;
   logic avrprog, nrst_en, nrst_val, pwr_off;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mask_q    <= '0;
         mode_q    <= '0;
         io_ctrl_q <= '0;   // all pins float
      end else if (bus_i.wr) begin
         case (bus_i.addr)
            cw_bus_pkg::ADDR_TRIG_MASK: mask_q    <= bus_i.wdata[3:0];
            cw_bus_pkg::ADDR_TRIG_MODE: mode_q    <= bus_i.wdata[1:0];
            cw_bus_pkg::ADDR_IO_CTRL:   io_ctrl_q <= bus_i.wdata[3:0];
            default: ;
         endcase
      end
   end

   // unselected lines count as 1 for AND, empty mask never fires
   assign and_hit  = (mask_q != 4'h0) && ((target_io_i | ~mask_q) == 4'hf);
   assign or_hit   = |(target_io_i & mask_q);
   assign trig_raw = (mode_q[0] ? and_hit : or_hit) ^ mode_q[1];

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i)
         trig_q <= 1'b0;
      else
         trig_q <= trig_raw;
   end

   assign trig_o = trig_q;

   assign avrprog  = io_ctrl_q[cw_target_pkg::BIT_AVRPROG];
   assign nrst_en  = io_ctrl_q[cw_target_pkg::BIT_NRST_EN];
   assign nrst_val = io_ctrl_q[cw_target_pkg::BIT_NRST_VAL];
   assign pwr_off  = io_ctrl_q[cw_target_pkg::BIT_PWR_OFF];

   // pin priority: power off, then ISP, then manual nrst
   always_comb begin
      target_nrst_o = '{val: 1'b0, oe: 1'b0};
      target_mosi_o = '{val: 1'b0, oe: 1'b0};
      target_sck_o  = '{val: 1'b0, oe: 1'b0};
      if (!pwr_off) begin
         if (avrprog) begin
            target_nrst_o = '{val: 1'b0, oe: 1'b1};        // hold target in reset
            target_mosi_o = '{val: sam_mosi_i, oe: 1'b1};
            target_sck_o  = '{val: sam_spck_i, oe: 1'b1};
         end else if (nrst_en) begin
            target_nrst_o = '{val: nrst_val, oe: 1'b1};
         end
      end
      sam_miso_o = '{val: target_miso_i, oe: avrprog};     // not gated by power
   end

   always_comb begin
      rdata_o = '0;
      if (bus_i.rd) begin
         case (bus_i.addr)
            cw_bus_pkg::ADDR_TRIG_MASK: rdata_o = {4'b0, mask_q};
            cw_bus_pkg::ADDR_TRIG_MODE: rdata_o = {6'b0, mode_q};
            cw_bus_pkg::ADDR_IO_CTRL:   rdata_o = {4'b0, io_ctrl_q};
            default:                    rdata_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/usb_reg_main.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_reg_main (
   input  wire                    clk_usb_buf,
   input  wire                    rst_n_i,
   input  wire [7:0]              usb_addr_i,
   input  wire [7:0]              usb_data_i,
   input  wire                    usb_rdn_i,
   input  wire                    usb_wrn_i,
   input  wire                    usb_cen_i,
   input  wire                    usb_alen_i,
   input  cw_bus_pkg::rdata_t     rdata_i,     // OR of all blocks
   output cw_bus_pkg::reg_bus_t   bus_o,
   output logic [7:0]             usb_data_o,
   output logic                   usb_data_oe_o
);

   // sampled host pins
   logic       rdn_s, wrn_s, cen_s, alen_s;
   logic       rdn_d, wrn_d;               // previous samples for edges
   logic [7:0] addr_s, data_s;

   logic       rd_edge, wr_edge;
   logic       rd_q, wr_q;
   logic       addrvalid_q;
   logic [7:0] addr_q;
   logic [7:0] wdata_q;
   logic [cw_bus_pkg::BYTECNT_W-1:0] bytecnt_q;

   // strobes idle high
   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdn_s  <= 1'b1;
         wrn_s  <= 1'b1;
         cen_s  <= 1'b1;
         alen_s <= 1'b1;
         rdn_d  <= 1'b1;
         wrn_d  <= 1'b1;
      end else begin
         rdn_s  <= usb_rdn_i;
         wrn_s  <= usb_wrn_i;
         cen_s  <= usb_cen_i;
         alen_s <= usb_alen_i;
         rdn_d  <= rdn_s;
         wrn_d  <= wrn_s;
      end
   end

   // sampled host address and data
   always_ff @(posedge clk_usb_buf) begin
      addr_s <= usb_addr_i;
      data_s <= usb_data_i;
   end

   assign wr_edge = wrn_s & ~wrn_d & ~cen_s;   // end of write strobe
   assign rd_edge = ~rdn_s & rdn_d & ~cen_s;   // start of read strobe

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_q        <= 1'b0;
         wr_q        <= 1'b0;
         addrvalid_q <= 1'b0;
         addr_q      <= '0;
         bytecnt_q   <= '0;
      end else begin
         rd_q <= rd_edge;
         wr_q <= wr_edge;
         if (!alen_s) begin
            addr_q      <= addr_s;
            bytecnt_q   <= '0;            // new burst
            addrvalid_q <= 1'b1;          // stays until reset
         end else if (rd_q || wr_q) begin
            bytecnt_q <= bytecnt_q + 1'b1; // step after the pulse
         end
      end
   end

   // write data captured at the wrn rising edge
   always_ff @(posedge clk_usb_buf) begin
      if (wr_edge)
         wdata_q <= data_s;
   end

   // read data valid 2 cycles after the rdn fall is seen
   always_ff @(posedge clk_usb_buf) begin
      if (rd_q)
         usb_data_o <= rdata_i;
   end

   assign usb_data_oe_o = ~cen_s & ~rdn_s;

   always_comb begin
      bus_o.addr      = addr_q;
      bus_o.bytecnt   = bytecnt_q;
      bus_o.wdata     = wdata_q;
      bus_o.rd        = rd_q;
      bus_o.wr        = wr_q;
      bus_o.addrvalid = addrvalid_q;
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_cw_capture_top -f cw_capture_top.f \
   -o tb_cw_capture_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_cw_capture_top > sim.log 2>&1 || true
cat sim.log
grep -qxF '** PASS **' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verif/tb_cw_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cw_capture_top;

   localparam int          HB_BIT         = 3;
   localparam int          HB_HALF        = 1 << HB_BIT;   // led half period in cycles
   localparam int          TIMEOUT_CYCLES = 20000;         // tests need about 4k cycles
   localparam logic [31:0] LFSR_SEED      = 32'h9165_fa7b;
   localparam logic [31:0] LFSR_POLY      = 32'h8020_0003; // x^32+x^22+x^2+x+1

   logic       clk_usb_buf;
   logic       rst_n_i;
   logic [7:0] usb_addr_i, usb_data_i;
   logic       usb_rdn_i, usb_wrn_i, usb_cen_i, usb_alen_i;
   logic [7:0] usb_data_o;
   logic       usb_data_oe_o;
   logic       adc_reset_o, adc_oe_o, adc_dfs_o, adc_sclk_o, adc_sdata_o, adc_sen_o;
   logic [4:0] vmag_o;
   logic [3:0] target_io_i;
   logic       sam_mosi_i, sam_spck_i, target_miso_i, trig_o;
   cw_target_pkg::pin_drive_t target_nrst_o, target_mosi_o, target_sck_o, sam_miso_o;
   logic       fifo_error_i, dcm_unlock_i, led_fail_o;

   logic [31:0] lfsr       = LFSR_SEED;
   int          errors     = 0;   // procedural checks
   int          sva_errors = 0;   // concurrent checks
   int          checks     = 0;
   int          cyc        = 0;   // free-running cycle count and led reference
   logic [15:0] mon_word   = '0;  // bits seen on the ADC serial pins
   int          mon_bits   = 0;
   int          sen_falls  = 0;

   cw_capture_top #(.hb_bit(HB_BIT)) dut (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #4 clk_usb_buf = ~clk_usb_buf;   // 8 ns
   end

   always @(posedge clk_usb_buf) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, test did not finish", cyc);
         $display("** FAIL **");
         $finish;
      end
   end

   // ADC samples on the sclk rise inside the sen window
   always @(posedge adc_sclk_o) begin
      if (!adc_sen_o) begin
         mon_word <= {mon_word[14:0], adc_sdata_o};
         mon_bits <= mon_bits + 1;
      end
   end

   always @(negedge adc_sen_o) begin
      sen_falls <= sen_falls + 1;
   end

   // no serial clock outside a word
   assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i) adc_sen_o |-> !adc_sclk_o)
      else begin
         sva_errors++;
         $display("adc_sclk_o high while adc_sen_o is idle at cycle %0d", cyc);
      end

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // AND or OR over the selected lines then optional invert
   function automatic logic trig_model(input logic [3:0] mask, input logic [1:0] mode,
                                       input logic [3:0] io);
      logic hit;
      if (mode[0])
         hit = (mask != 4'h0) && ((io & mask) == mask);
      else
         hit = (io & mask) != 4'h0;
      return hit ^ mode[1];
   endfunction

   task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("MISMATCH %s got %0h exp %0h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   task automatic report_fail(input string what);
      errors++;
      $display("ERROR %s at cycle %0d", what, cyc);
   endtask

   task automatic check_pin(input string name, input cw_target_pkg::pin_drive_t p,
                            input logic oe, input logic val);
      check_hex({name, ".oe"}, 32'(p.oe), 32'(oe));
      if (oe)
         check_hex({name, ".val"}, 32'(p.val), 32'(val));   // val is don't care when off
   endtask

   task automatic tick(input int n);
      repeat (n) @(posedge clk_usb_buf);
      #1;   // drive just after the edge
   endtask

   task automatic bus_addr(input logic [7:0] a);
      usb_addr_i = a;
      usb_alen_i = 1'b0;
      tick(3);
      usb_alen_i = 1'b1;
      tick(1);
   endtask

   task automatic bus_write(input logic [7:0] d);
      usb_data_i = d;
      usb_cen_i  = 1'b0;
      usb_wrn_i  = 1'b0;
      tick(3);
      usb_wrn_i  = 1'b1;
      tick(3);   // cen and data held past the write pulse
      usb_cen_i  = 1'b1;
      tick(1);
   endtask

   task automatic bus_read(output logic [7:0] d);
      usb_cen_i = 1'b0;
      usb_rdn_i = 1'b0;
      tick(4);
      d = usb_data_o;
      check_hex("usb_data_oe_o", 32'(usb_data_oe_o), 32'h1);
      usb_rdn_i = 1'b1;
      usb_cen_i = 1'b1;
      tick(2);
   endtask

   task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
      bus_addr(a);
      bus_write(d);
   endtask

   task automatic read_check(input string name, input logic [7:0] a, input logic [7:0] exp);
      logic [7:0] d;
      bus_addr(a);
      bus_read(d);
      check_hex(name, 32'(d), 32'(exp));
   endtask

   task automatic test_readback();
      logic [7:0] v;
      int         i;
      for (i = 0; i < 8; i++) begin
         v = 8'(rand_bits(8));
         write_reg(cw_bus_pkg::ADDR_ADC_CTRL, v);
         read_check("adc_ctrl", cw_bus_pkg::ADDR_ADC_CTRL, v & 8'h07);
         check_hex("adc_reset_o", 32'(adc_reset_o), 32'(v[0]));
         check_hex("adc_oe_o", 32'(adc_oe_o), 32'(v[1]));
         check_hex("adc_dfs_o", 32'(adc_dfs_o), 32'(v[2]));
         v = 8'(rand_bits(8));
         write_reg(cw_bus_pkg::ADDR_VMAG, v);
         read_check("vmag", cw_bus_pkg::ADDR_VMAG, v & 8'h1f);
         check_hex("vmag_o", 32'(vmag_o), 32'(v[4:0]));
         v = 8'(rand_bits(8));
         write_reg(cw_bus_pkg::ADDR_TRIG_MASK, v);
         read_check("trig_mask", cw_bus_pkg::ADDR_TRIG_MASK, v & 8'h0f);
         v = 8'(rand_bits(8));
         write_reg(cw_bus_pkg::ADDR_TRIG_MODE, v);
         read_check("trig_mode", cw_bus_pkg::ADDR_TRIG_MODE, v & 8'h03);
         v = 8'(rand_bits(8));
         write_reg(cw_bus_pkg::ADDR_IO_CTRL, v);
         read_check("io_ctrl", cw_bus_pkg::ADDR_IO_CTRL, v & 8'h0f);
      end
      // holes in the map
      read_check("unmapped 04", 8'h04, 8'h00);
      read_check("unmapped 13", 8'h13, 8'h00);
      read_check("unmapped 21", 8'h21, 8'h00);
      read_check("unmapped ff", 8'hff, 8'h00);
   endtask

   task automatic test_adc_serial();
      logic [15:0] w;
      int          bits0, falls0, n, i;
      for (i = 0; i < 6; i++) begin
         w      = 16'(rand_bits(16));
         bits0  = mon_bits;
         falls0 = sen_falls;
         bus_addr(cw_bus_pkg::ADDR_ADC_SPI);   // both bytes under one ALE
         bus_write(w[15:8]);
         bus_write(w[7:0]);
         n = 0;
         while (!(sen_falls > falls0 && adc_sen_o) && n < 400) begin
            tick(1);
            n++;
         end
         assert (n < 400) else report_fail("ADC serial word never completed");
         check_hex("adc serial word", 32'(mon_word), 32'(w));
         check_hex("adc serial bit count", 32'(mon_bits - bits0), 32'd16);
         read_check("adc busy", cw_bus_pkg::ADDR_ADC_STAT, 8'h00);
      end
   endtask

   task automatic test_trigger();
      logic [3:0] mask, io;
      logic [1:0] mode;
      int         i, j;
      for (i = 0; i < 16; i++) begin
         mask = 4'(rand_bits(4));
         mode = 2'(rand_bits(2));
         if (i < 4) begin
            mask = 4'h0;   // empty mask in every mode
            mode = 2'(i);
         end
         write_reg(cw_bus_pkg::ADDR_TRIG_MASK, {4'h0, mask});
         write_reg(cw_bus_pkg::ADDR_TRIG_MODE, {6'h0, mode});
         for (j = 0; j < 4; j++) begin
            io          = 4'(rand_bits(4));
            target_io_i = io;
            tick(1);   // trig_o one clock behind
            check_hex("trig_o", 32'(trig_o), 32'(trig_model(mask, mode, io)));
         end
      end
   endtask

   task automatic test_pins();
      logic [3:0] ctrl;
      logic       avr, nen, nval, off;
      int         i, j;
      for (i = 0; i < 16; i++) begin
         ctrl = 4'(i);   // every IO_CTRL combination
         avr  = ctrl[cw_target_pkg::BIT_AVRPROG];
         nen  = ctrl[cw_target_pkg::BIT_NRST_EN];
         nval = ctrl[cw_target_pkg::BIT_NRST_VAL];
         off  = ctrl[cw_target_pkg::BIT_PWR_OFF];
         write_reg(cw_bus_pkg::ADDR_IO_CTRL, {4'h0, ctrl});
         for (j = 0; j < 3; j++) begin
            sam_mosi_i    = 1'(rand_bits(1));
            sam_spck_i    = 1'(rand_bits(1));
            target_miso_i = 1'(rand_bits(1));
            tick(1);
            check_pin("target_nrst_o", target_nrst_o, !off && (avr || nen), avr ? 1'b0 : nval);
            check_pin("target_mosi_o", target_mosi_o, !off && avr, sam_mosi_i);
            check_pin("target_sck_o", target_sck_o, !off && avr, sam_spck_i);
            check_pin("sam_miso_o", sam_miso_o, avr, target_miso_i);
         end
      end
      write_reg(cw_bus_pkg::ADDR_IO_CTRL, 8'h00);
   endtask

   // led period against bit HB_BIT of the cycle count but not its phase
   task automatic check_led_flash();
      logic led_prev, cnt_prev;
      int   last, led_edges, cnt_edges, i;
      led_prev  = led_fail_o;
      cnt_prev  = cyc[HB_BIT];
      last      = -1;
      led_edges = 0;
      cnt_edges = 0;
      for (i = 0; i < 32; i++) begin
         dcm_unlock_i = 1'(rand_bits(1));   // must not matter while flagged
         tick(1);
         if (cyc[HB_BIT] != cnt_prev) begin
            cnt_edges++;
            cnt_prev = cyc[HB_BIT];
         end
         if (led_fail_o != led_prev) begin
            if (last >= 0)
               assert (i - last == HB_HALF) else report_fail("led_fail_o flash period wrong");
            last      = i;
            led_edges++;
            led_prev  = led_fail_o;
         end
      end
      assert (led_edges >= cnt_edges - 1 && led_edges <= cnt_edges + 1)
         else report_fail("led_fail_o does not toggle with heartbeat bit 3");
   endtask

   task automatic test_status();
      int i;
      read_check("err flags idle", cw_bus_pkg::ADDR_ERR, 8'h00);
      for (i = 0; i < 8; i++) begin
         dcm_unlock_i = 1'(rand_bits(1));
         tick(1);
         check_hex("led_fail_o", 32'(led_fail_o), 32'(dcm_unlock_i));
      end
      fifo_error_i = 1'b1;   // one-cycle error pulse
      tick(1);
      fifo_error_i = 1'b0;
      tick(1);
      read_check("err flags set", cw_bus_pkg::ADDR_ERR, 8'h01);
      check_led_flash();
      write_reg(cw_bus_pkg::ADDR_ERR, 8'h01);
      read_check("err flags cleared", cw_bus_pkg::ADDR_ERR, 8'h00);
      for (i = 0; i < 8; i++) begin
         dcm_unlock_i = 1'(rand_bits(1));
         tick(1);
         check_hex("led_fail_o", 32'(led_fail_o), 32'(dcm_unlock_i));
      end
   endtask

   initial begin
      rst_n_i       = 1'b0;
      usb_addr_i    = 8'h00;
      usb_data_i    = 8'h00;
      usb_rdn_i     = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_cen_i     = 1'b1;
      usb_alen_i    = 1'b1;
      target_io_i   = 4'h0;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      fifo_error_i  = 1'b0;
      dcm_unlock_i  = 1'b0;
      repeat (10) @(posedge clk_usb_buf);
      #1;
      rst_n_i = 1'b1;
      tick(1);
      // idle state straight out of reset
      check_hex("adc_sen_o", 32'(adc_sen_o), 32'h1);
      check_hex("adc_sclk_o", 32'(adc_sclk_o), 32'h0);
      check_hex("trig_o", 32'(trig_o), 32'h0);
      check_hex("target_nrst_o.oe", 32'(target_nrst_o.oe), 32'h0);
      check_hex("target_mosi_o.oe", 32'(target_mosi_o.oe), 32'h0);
      check_hex("target_sck_o.oe", 32'(target_sck_o.oe), 32'h0);
      check_hex("sam_miso_o.oe", 32'(sam_miso_o.oe), 32'h0);
      test_readback();
      test_adc_serial();
      test_trigger();
      test_pins();
      test_status();
      $display("checks %0d errors %0d assertion errors %0d", checks, errors, sva_errors);
      if (errors == 0 && sva_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
